/* src/ex_cfg.svh */
`ifndef EX_CFG_SVH
`define EX_CFG_SVH

// datapath and address width
`define EX_XLEN      32
`define EX_INST_W    32

// register file index
`define EX_REG_AW    5

// shift amount, low bits of op2 or imm
`define EX_SHAMT_W   5

// instruction field widths
`define EX_OPCODE_W  7
`define EX_FUNCT3_W  3
`define EX_FUNCT7_W  7

`endif

/* src/ex_isa_pkg.sv */
`default_nettype none
`include "ex_cfg.svh"

package ex_isa_pkg;

    // major opcodes
    localparam logic [`EX_OPCODE_W-1:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [`EX_OPCODE_W-1:0] OPC_OP     = 7'b0110011;
    localparam logic [`EX_OPCODE_W-1:0] OPC_BRANCH = 7'b1100011;

    // integer funct3, shared by imm and reg forms
    localparam logic [`EX_FUNCT3_W-1:0] F3_ADD_SUB = 3'b000;
    localparam logic [`EX_FUNCT3_W-1:0] F3_SLL     = 3'b001;
    localparam logic [`EX_FUNCT3_W-1:0] F3_SLT     = 3'b010;
    localparam logic [`EX_FUNCT3_W-1:0] F3_SLTU    = 3'b011;
    localparam logic [`EX_FUNCT3_W-1:0] F3_XOR     = 3'b100;
    localparam logic [`EX_FUNCT3_W-1:0] F3_SR      = 3'b101;
    localparam logic [`EX_FUNCT3_W-1:0] F3_OR      = 3'b110;
    localparam logic [`EX_FUNCT3_W-1:0] F3_AND     = 3'b111;

    localparam logic [`EX_FUNCT3_W-1:0] F3_MUL     = 3'b000;
    localparam logic [`EX_FUNCT3_W-1:0] F3_MULH    = 3'b001;
    localparam logic [`EX_FUNCT3_W-1:0] F3_MULHSU  = 3'b010;
    localparam logic [`EX_FUNCT3_W-1:0] F3_MULHU   = 3'b011;

    localparam logic [`EX_FUNCT3_W-1:0] F3_BEQ     = 3'b000;
    localparam logic [`EX_FUNCT3_W-1:0] F3_BNE     = 3'b001;
    localparam logic [`EX_FUNCT3_W-1:0] F3_BLT     = 3'b100;
    localparam logic [`EX_FUNCT3_W-1:0] F3_BGE     = 3'b101;
    localparam logic [`EX_FUNCT3_W-1:0] F3_BLTU    = 3'b110;
    localparam logic [`EX_FUNCT3_W-1:0] F3_BGEU    = 3'b111;

    localparam logic [`EX_FUNCT7_W-1:0] F7_BASE    = 7'b0000000;
    localparam logic [`EX_FUNCT7_W-1:0] F7_ALT     = 7'b0100000; // sub, sra
    localparam logic [`EX_FUNCT7_W-1:0] F7_MULDIV  = 7'b0000001;

    typedef enum logic [4:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_OR, ALU_AND,
        ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_MUL, ALU_MULH, ALU_MULHSU, ALU_MULHU,
        ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU,
        ALU_NONE
    } alu_op_e;

endpackage

`default_nettype wire

/* src/ex_pipe_pkg.sv */
`default_nettype none
`include "ex_cfg.svh"

package ex_pipe_pkg;

    // one instruction from the issue side
    typedef struct packed {
        logic                     valid;
        logic [`EX_INST_W-1:0]    inst;
        logic [`EX_XLEN-1:0]      op1;      // compare / alu operands
        logic [`EX_XLEN-1:0]      op2;
        logic [`EX_XLEN-1:0]      op1_jump; // branch target addends
        logic [`EX_XLEN-1:0]      op2_jump;
        logic [`EX_XLEN-1:0]      rs1_data;
        logic [`EX_XLEN-1:0]      rs2_data;
        logic                     reg_we;
        logic [`EX_REG_AW-1:0]    reg_waddr;
    } ex_req_t;

    // stage one register
    typedef struct packed {
        logic                     valid;
        ex_isa_pkg::alu_op_e      op;
        logic [`EX_XLEN-1:0]      op1;
        logic [`EX_XLEN-1:0]      op2;
        logic [`EX_XLEN-1:0]      rs1_data;
        logic [`EX_XLEN-1:0]      rs2_data;
        logic [`EX_SHAMT_W-1:0]   shamt;
        logic [`EX_XLEN-1:0]      target;   // already summed
        logic                     reg_we;
        logic [`EX_REG_AW-1:0]    reg_waddr;
    } ex_op_t;

    // retire record
    typedef struct packed {
        logic                     valid;
        logic                     reg_we;
        logic [`EX_REG_AW-1:0]    reg_waddr;
        logic [`EX_XLEN-1:0]      reg_wdata;
        logic                     jump_flag;
        logic [`EX_XLEN-1:0]      jump_addr;
    } ex_wb_t;

endpackage

`default_nettype wire

/* src/ex_decode.sv */
`default_nettype none
`include "ex_cfg.svh"

module ex_decode (
    input  wire                       clk,
    input  wire                       rst_n_i,
    input  wire ex_pipe_pkg::ex_req_t req_i,
    output ex_pipe_pkg::ex_op_t       op_o
);

    import ex_isa_pkg::*;
    import ex_pipe_pkg::*;

    logic [`EX_OPCODE_W-1:0] opcode;
    logic [`EX_FUNCT3_W-1:0] funct3;
    logic [`EX_FUNCT7_W-1:0] funct7;
    logic                    alt;
    alu_op_e                 dec_op;
    ex_op_t                  op_d;

    assign opcode = req_i.inst[`EX_OPCODE_W-1:0];
    assign funct3 = req_i.inst[14:12];
    assign funct7 = req_i.inst[31:25];
    assign alt    = req_i.inst[30]; // sub / sra select

    always_comb begin
        dec_op = ALU_NONE;
        case (opcode)
            OPC_OP_IMM: begin
                case (funct3)
                    F3_ADD_SUB: dec_op = ALU_ADD;
                    F3_SLT:     dec_op = ALU_SLT;
                    F3_SLTU:    dec_op = ALU_SLTU;
                    F3_XOR:     dec_op = ALU_XOR;
                    F3_OR:      dec_op = ALU_OR;
                    F3_AND:     dec_op = ALU_AND;
                    F3_SLL:     dec_op = (funct7 == F7_BASE) ? ALU_SLL : ALU_NONE;
                    F3_SR: begin
                        if (funct7 == F7_BASE) begin
                            dec_op = ALU_SRL;
                        end else if (funct7 == F7_ALT) begin
                            dec_op = ALU_SRA;
                        end
                    end
                    default: ;
                endcase
            end
            OPC_OP: begin
                if (funct7 == F7_MULDIV) begin
                    case (funct3)
                        F3_MUL:    dec_op = ALU_MUL;
                        F3_MULH:   dec_op = ALU_MULH;
                        F3_MULHSU: dec_op = ALU_MULHSU;
                        F3_MULHU:  dec_op = ALU_MULHU;
                        default: ; // div / rem not handled here
                    endcase
                end else if (funct7 == F7_BASE || funct7 == F7_ALT) begin
                    case (funct3)
                        F3_ADD_SUB: dec_op = alt ? ALU_SUB : ALU_ADD;
                        F3_SR:      dec_op = alt ? ALU_SRA : ALU_SRL;
                        F3_SLL:     dec_op = alt ? ALU_NONE : ALU_SLL;
                        F3_SLT:     dec_op = alt ? ALU_NONE : ALU_SLT;
                        F3_SLTU:    dec_op = alt ? ALU_NONE : ALU_SLTU;
                        F3_XOR:     dec_op = alt ? ALU_NONE : ALU_XOR;
                        F3_OR:      dec_op = alt ? ALU_NONE : ALU_OR;
                        default:    dec_op = alt ? ALU_NONE : ALU_AND;
                    endcase
                end
            end
            OPC_BRANCH: begin
                case (funct3)
                    F3_BEQ:  dec_op = ALU_BEQ;
                    F3_BNE:  dec_op = ALU_BNE;
                    F3_BLT:  dec_op = ALU_BLT;
                    F3_BGE:  dec_op = ALU_BGE;
                    F3_BLTU: dec_op = ALU_BLTU;
                    F3_BGEU: dec_op = ALU_BGEU;
                    default: ;
                endcase
            end
            default: ;
        endcase
    end

    always_comb begin
        op_d.valid     = req_i.valid;
        op_d.op        = dec_op;
        op_d.op1       = req_i.op1;
        op_d.op2       = req_i.op2;
        op_d.rs1_data  = req_i.rs1_data;
        op_d.rs2_data  = req_i.rs2_data;
        // imm shifts carry shamt in the instruction
        op_d.shamt     = (opcode == OPC_OP_IMM) ? req_i.inst[24:20]
                                                : req_i.op2[`EX_SHAMT_W-1:0];
        op_d.target    = req_i.op1_jump + req_i.op2_jump;
        op_d.reg_we    = req_i.reg_we && (dec_op != ALU_NONE);
        op_d.reg_waddr = req_i.reg_waddr;
    end

    always_ff @(posedge clk) begin
        op_o <= op_d;
        if (!rst_n_i) begin
            op_o.valid  <= 1'b0;
            op_o.reg_we <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* src/ex_alu.sv */
`default_nettype none
`include "ex_cfg.svh"

module ex_alu (
    input  wire ex_pipe_pkg::ex_op_t op_i,
    output logic [`EX_XLEN-1:0]      result_o,
    output logic                     jump_o,
    output logic [`EX_XLEN-1:0]      jump_addr_o
);

    import ex_isa_pkg::*;

    logic [`EX_XLEN-1:0] sum;
    logic [`EX_XLEN-1:0] diff;
    logic [`EX_XLEN-1:0] srl_res;
    logic [`EX_XLEN-1:0] sra_fill;
    logic                lt_s;
    logic                lt_u;
    logic                eq;

    assign sum     = op_i.op1 + op_i.op2;
    assign diff    = op_i.op1 - op_i.op2;
    assign srl_res = op_i.op1 >> op_i.shamt;
    // vacated upper bits take the sign of rs1
    assign sra_fill = ~({`EX_XLEN{1'b1}} >> op_i.shamt)
                      & {`EX_XLEN{op_i.rs1_data[`EX_XLEN-1]}};

    // shared by slt/sltu and the branches
    assign lt_s = $signed(op_i.op1) < $signed(op_i.op2);
    assign lt_u = op_i.op1 < op_i.op2;
    assign eq   = op_i.op1 == op_i.op2;

    always_comb begin
        result_o = '0;
        jump_o   = 1'b0;
        case (op_i.op)
            ALU_ADD:  result_o = sum;
            ALU_SUB:  result_o = diff;
            ALU_SLT:  result_o = {{(`EX_XLEN-1){1'b0}}, lt_s};
            ALU_SLTU: result_o = {{(`EX_XLEN-1){1'b0}}, lt_u};
            ALU_XOR:  result_o = op_i.op1 ^ op_i.op2;
            ALU_OR:   result_o = op_i.op1 | op_i.op2;
            ALU_AND:  result_o = op_i.op1 & op_i.op2;
            ALU_SLL:  result_o = op_i.op1 << op_i.shamt;
            ALU_SRL:  result_o = srl_res;
            ALU_SRA:  result_o = srl_res | sra_fill;
            ALU_BEQ:  jump_o   = eq;
            ALU_BNE:  jump_o   = !eq;
            ALU_BLT:  jump_o   = lt_s;
            ALU_BGE:  jump_o   = !lt_s;
            ALU_BLTU: jump_o   = lt_u;
            ALU_BGEU: jump_o   = !lt_u;
            default: ;
        endcase
    end

    assign jump_addr_o = jump_o ? op_i.target : '0;

endmodule

`default_nettype wire

/* src/ex_mul.sv */
`default_nettype none
`include "ex_cfg.svh"

module ex_mul (
    input  wire ex_pipe_pkg::ex_op_t op_i,
    output logic [`EX_XLEN-1:0]      product_o
);

    import ex_isa_pkg::*;

    logic                  neg_a;
    logic                  neg_b;
    logic [`EX_XLEN-1:0]   mag_a;
    logic [`EX_XLEN-1:0]   mag_b;
    logic [2*`EX_XLEN-1:0] mag_prod;
    logic [2*`EX_XLEN-1:0] prod;

    // rs1 is signed for mulh and mulhsu, rs2 only for mulh
    assign neg_a = op_i.rs1_data[`EX_XLEN-1]
                   && (op_i.op == ALU_MULH || op_i.op == ALU_MULHSU);
    assign neg_b = op_i.rs2_data[`EX_XLEN-1] && (op_i.op == ALU_MULH);

    assign mag_a = neg_a ? (~op_i.rs1_data + 1'b1) : op_i.rs1_data;
    assign mag_b = neg_b ? (~op_i.rs2_data + 1'b1) : op_i.rs2_data;

    assign mag_prod = mag_a * mag_b; // unsigned 64 bit

    assign prod = (neg_a ^ neg_b) ? (~mag_prod + 1'b1) : mag_prod;

    // mul wants the low word, mulh* the high word
    assign product_o = (op_i.op == ALU_MUL) ? prod[`EX_XLEN-1:0]
                                            : prod[2*`EX_XLEN-1:`EX_XLEN];

endmodule

`default_nettype wire

/* src/ex_writeback.sv */
`default_nettype none
`include "ex_cfg.svh"

module ex_writeback (
    input  wire                      clk,
    input  wire                      rst_n_i,
    input  wire ex_pipe_pkg::ex_op_t op_i,
    input  wire [`EX_XLEN-1:0]       alu_result_i,
    input  wire [`EX_XLEN-1:0]       mul_product_i,
    input  wire                      jump_i,
    input  wire [`EX_XLEN-1:0]       jump_addr_i,
    output ex_pipe_pkg::ex_wb_t      wb_o
);

    import ex_isa_pkg::*;
    import ex_pipe_pkg::*;

    logic   is_mul;
    logic   writes;
    ex_wb_t wb_d;

    assign is_mul = op_i.op inside {ALU_MUL, ALU_MULH, ALU_MULHSU, ALU_MULHU};

    // branches and unknown ops never touch the register file
    assign writes = !(op_i.op inside {ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE,
                                      ALU_BLTU, ALU_BGEU, ALU_NONE});

    always_comb begin
        wb_d.valid     = op_i.valid;
        wb_d.reg_we    = op_i.valid && op_i.reg_we && writes;
        wb_d.reg_waddr = op_i.reg_waddr;
        if (writes) begin
            wb_d.reg_wdata = is_mul ? mul_product_i : alu_result_i;
        end else begin
            wb_d.reg_wdata = '0;
        end
        wb_d.jump_flag = op_i.valid && jump_i; // bubbles never jump
        wb_d.jump_addr = wb_d.jump_flag ? jump_addr_i : '0;
    end

    always_ff @(posedge clk) begin
        wb_o <= wb_d;
        if (!rst_n_i) begin
            wb_o.valid     <= 1'b0;
            wb_o.reg_we    <= 1'b0;
            wb_o.jump_flag <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* src/ex_unit.sv */
`default_nettype none
`include "ex_cfg.svh"

module ex_unit (
    input  wire                       clk,
    input  wire                       rst_n_i,
    input  wire ex_pipe_pkg::ex_req_t req_i,
    output ex_pipe_pkg::ex_wb_t       wb_o
);

    ex_pipe_pkg::ex_op_t  op_q;         // stage one register
    logic [`EX_XLEN-1:0]  alu_result;
    logic [`EX_XLEN-1:0]  mul_product;
    logic                 jump;
    logic [`EX_XLEN-1:0]  jump_addr;

    ex_decode u_decode (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .req_i       (req_i),
        .op_o        (op_q)
    );

    ex_alu u_alu (
        .op_i        (op_q),
        .result_o    (alu_result),
        .jump_o      (jump),
        .jump_addr_o (jump_addr)
    );

    ex_mul u_mul (
        .op_i        (op_q),
        .product_o   (mul_product)
    );

    ex_writeback u_writeback (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .op_i          (op_q),
        .alu_result_i  (alu_result),
        .mul_product_i (mul_product),
        .jump_i        (jump),
        .jump_addr_i   (jump_addr),
        .wb_o          (wb_o)
    );

endmodule

`default_nettype wire

/* bench/ex_checker.sv */
`default_nettype none

module ex_checker (
    input wire                      clk,
    input wire                      rst_n_i,
    input wire ex_pipe_pkg::ex_wb_t wb_i
);

    import ex_pipe_pkg::*;

    ex_wb_t      exp_q[$];
    string       name_q[$];
    int unsigned due_q[$]; // cycle in which the record must show up
    int unsigned cyc    = 0;
    int          n_pass = 0;
    int          n_fail = 0;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    task automatic push_expect(input string name, input ex_wb_t exp);
        name_q.push_back(name);
        exp_q.push_back(exp);
        due_q.push_back(cyc + 2); // two register stages
    endtask

    function automatic int pending();
        return exp_q.size();
    endfunction

    function automatic int error_count();
        return n_fail;
    endfunction

    // sample away from the rising edge
    always @(negedge clk) begin
        if (rst_n_i) begin
            if (exp_q.size() != 0 && due_q[0] == cyc) begin
                if (wb_i.valid !== 1'b1) begin
                    $display("%s: no valid output arrived in cycle %0d", name_q[0], cyc);
                    n_fail++;
                end else if (wb_i !== exp_q[0]) begin
                    $display("[FAIL] %s expected %h actual %h", name_q[0], exp_q[0], wb_i);
                    n_fail++;
                end else begin
                    $display("[PASS] %s", name_q[0]);
                    n_pass++;
                end
                void'(name_q.pop_front());
                void'(exp_q.pop_front());
                void'(due_q.pop_front());
            end else if (wb_i.valid !== 1'b0) begin
                $display("output valid in cycle %0d while no test was due", cyc);
                n_fail++;
            end
        end
    end

    task automatic summarize();
        if (exp_q.size() != 0) begin
            $display("%0d expected outputs never arrived, first one is %s",
                     exp_q.size(), name_q[0]);
            n_fail += exp_q.size();
        end
        $display("tests: %0d passed, %0d failed", n_pass, n_fail);
    endtask

endmodule

`default_nettype wire

/* bench/tb_ex_unit.sv */
`default_nettype none
`include "ex_cfg.svh"

module tb_ex_unit;

    import ex_isa_pkg::*;
    import ex_pipe_pkg::*;

    logic    clk;
    logic    rst_n;
    ex_req_t req;
    ex_wb_t  wb;

    // stimulus table, one entry per test
    ex_req_t rows[$];
    alu_op_e ops[$];
    string   names[$];
    bit      gaps[$];    // idle cycle after the row
    bit      table_ready = 1'b0;

    ex_unit i_dut (
        .clk     (clk),
        .rst_n_i (rst_n),
        .req_i   (req),
        .wb_o    (wb)
    );

    ex_checker i_chk (
        .clk     (clk),
        .rst_n_i (rst_n),
        .wb_i    (wb)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [`EX_XLEN-1:0] sext12(input logic [11:0] imm);
        return {{20{imm[11]}}, imm};
    endfunction

    function automatic logic [4:0] next_rd();
        return 5'(rows.size() % 31 + 1);
    endfunction

    // expected retire record from the ISA rules
    function automatic ex_wb_t expect_wb(input alu_op_e op, input ex_req_t r);
        ex_wb_t      w;
        logic [63:0] ext_a;
        logic [63:0] ext_b;
        logic [63:0] prod;
        logic [4:0]  sh;
        logic        taken;
        w           = '0;
        w.valid     = 1'b1;
        w.reg_we    = r.reg_we;
        w.reg_waddr = r.reg_waddr;
        sh          = r.op2[4:0];
        taken       = 1'b0;
        ext_a = {{32{r.rs1_data[31] & (op == ALU_MULH || op == ALU_MULHSU)}}, r.rs1_data};
        ext_b = {{32{r.rs2_data[31] & (op == ALU_MULH)}}, r.rs2_data};
        prod  = ext_a * ext_b; // low 64 bits are exact
        case (op)
            ALU_ADD:    w.reg_wdata = r.op1 + r.op2;
            ALU_SUB:    w.reg_wdata = r.op1 - r.op2;
            ALU_SLT:    w.reg_wdata = 32'($signed(r.op1) < $signed(r.op2));
            ALU_SLTU:   w.reg_wdata = 32'(r.op1 < r.op2);
            ALU_XOR:    w.reg_wdata = r.op1 ^ r.op2;
            ALU_OR:     w.reg_wdata = r.op1 | r.op2;
            ALU_AND:    w.reg_wdata = r.op1 & r.op2;
            ALU_SLL:    w.reg_wdata = r.op1 << sh;
            ALU_SRL:    w.reg_wdata = r.op1 >> sh;
            ALU_SRA:    w.reg_wdata = $unsigned($signed(r.op1) >>> sh);
            ALU_MUL:    w.reg_wdata = prod[31:0];
            ALU_MULH,
            ALU_MULHSU,
            ALU_MULHU:  w.reg_wdata = prod[63:32];
            ALU_BEQ:    taken = (r.op1 == r.op2);
            ALU_BNE:    taken = (r.op1 != r.op2);
            ALU_BLT:    taken = ($signed(r.op1) < $signed(r.op2));
            ALU_BGE:    taken = ($signed(r.op1) >= $signed(r.op2));
            ALU_BLTU:   taken = (r.op1 < r.op2);
            ALU_BGEU:   taken = (r.op1 >= r.op2);
            default: ;
        endcase
        if (op inside {ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU, ALU_NONE}) begin
            w.reg_we = 1'b0;
        end
        w.jump_flag = taken;
        w.jump_addr = taken ? r.op1_jump + r.op2_jump : '0;
        return w;
    endfunction

    task automatic add_row(input string name, input alu_op_e op, input logic [31:0] inst,
                           input logic [31:0] a, input logic [31:0] b);
        ex_req_t r;
        r.valid     = 1'b1;
        r.inst      = inst;
        r.op1       = a;
        r.op2       = b;
        r.op1_jump  = $urandom;
        r.op2_jump  = $urandom;
        r.rs1_data  = a;
        r.rs2_data  = b;
        r.reg_we    = 1'b1;
        r.reg_waddr = inst[11:7];
        rows.push_back(r);
        ops.push_back(op);
        names.push_back(name);
        gaps.push_back(rows.size() % 7 == 0);
    endtask

    task automatic add_imm(input string name, input alu_op_e op, input logic [2:0] f3,
                           input logic [11:0] imm, input logic [31:0] a);
        add_row(name, op, {imm, 5'd1, f3, next_rd(), OPC_OP_IMM}, a, sext12(imm));
    endtask

    task automatic add_reg(input string name, input alu_op_e op, input logic [6:0] f7,
                           input logic [2:0] f3, input logic [31:0] a, input logic [31:0] b);
        add_row(name, op, {f7, 5'd2, 5'd1, f3, next_rd(), OPC_OP}, a, b);
    endtask

    task automatic add_br(input string name, input alu_op_e op, input logic [2:0] f3,
                          input logic [31:0] a, input logic [31:0] b);
        add_row(name, op, {7'd0, 5'd2, 5'd1, f3, 5'd8, OPC_BRANCH}, a, b);
    endtask

    task automatic build_table();
        logic [31:0] x;
        logic [31:0] y;
        logic [31:0] neg;
        logic [31:0] pos;
        ex_req_t     last;
        x   = $urandom;
        y   = $urandom;
        neg = $urandom | 32'h8000_0000;
        pos = $urandom & 32'h7fff_ffff;
        add_imm("addi", ALU_ADD, F3_ADD_SUB, 12'h800, x);
        add_imm("slti", ALU_SLT, F3_SLT, 12'hfff, neg); // -1 against a negative
        add_imm("sltiu", ALU_SLTU, F3_SLTU, 12'hfff, x);
        add_imm("xori", ALU_XOR, F3_XOR, 12'h5a3, x);
        add_imm("ori", ALU_OR, F3_OR, 12'h0f0, x);
        add_imm("andi", ALU_AND, F3_AND, 12'hf0f, x);
        add_imm("slli", ALU_SLL, F3_SLL, 12'h007, x);
        add_imm("srli", ALU_SRL, F3_SR, 12'h00d, neg);
        add_imm("srai", ALU_SRA, F3_SR, 12'h409, neg);
        add_reg("add", ALU_ADD, F7_BASE, F3_ADD_SUB, x, y);
        add_reg("add_no_we", ALU_ADD, F7_BASE, F3_ADD_SUB, y, x);
        last = rows.pop_back();
        last.reg_we = 1'b0; // issue side withholds the write
        rows.push_back(last);
        add_reg("sub_neg", ALU_SUB, F7_ALT, F3_ADD_SUB, 32'hffff_fffb, 32'd9);
        add_reg("sub", ALU_SUB, F7_ALT, F3_ADD_SUB, y, x);
        add_reg("sll", ALU_SLL, F7_BASE, F3_SLL, x, y);
        add_reg("srl", ALU_SRL, F7_BASE, F3_SR, neg, y);
        add_reg("sra_neg", ALU_SRA, F7_ALT, F3_SR, neg, y);
        add_reg("sra_pos", ALU_SRA, F7_ALT, F3_SR, pos, 32'd4);
        add_reg("slt_np", ALU_SLT, F7_BASE, F3_SLT, neg, pos);
        add_reg("sltu_np", ALU_SLTU, F7_BASE, F3_SLTU, neg, pos);
        add_reg("slt_pn", ALU_SLT, F7_BASE, F3_SLT, pos, neg);
        add_reg("sltu_pn", ALU_SLTU, F7_BASE, F3_SLTU, pos, neg);
        add_reg("xor", ALU_XOR, F7_BASE, F3_XOR, x, y);
        add_reg("or", ALU_OR, F7_BASE, F3_OR, x, y);
        add_reg("and", ALU_AND, F7_BASE, F3_AND, x, y);
        // all four sign combinations
        for (int s = 0; s < 4; s++) begin
            x = {s[1], 31'($urandom)};
            y = {s[0], 31'($urandom)};
            add_reg($sformatf("mul_%0d", s), ALU_MUL, F7_MULDIV, F3_MUL, x, y);
            add_reg($sformatf("mulh_%0d", s), ALU_MULH, F7_MULDIV, F3_MULH, x, y);
            add_reg($sformatf("mulhsu_%0d", s), ALU_MULHSU, F7_MULDIV, F3_MULHSU, x, y);
            add_reg($sformatf("mulhu_%0d", s), ALU_MULHU, F7_MULDIV, F3_MULHU, x, y);
        end
        // equal, neg vs pos, pos vs neg
        for (int p = 0; p < 3; p++) begin
            x = $urandom & 32'h7fff_ffff;
            y = x;
            if (p == 1) x = x | 32'h8000_0000;
            if (p == 2) y = y | 32'h8000_0000;
            add_br($sformatf("beq_%0d", p), ALU_BEQ, F3_BEQ, x, y);
            add_br($sformatf("bne_%0d", p), ALU_BNE, F3_BNE, x, y);
            add_br($sformatf("blt_%0d", p), ALU_BLT, F3_BLT, x, y);
            add_br($sformatf("bge_%0d", p), ALU_BGE, F3_BGE, x, y);
            add_br($sformatf("bltu_%0d", p), ALU_BLTU, F3_BLTU, x, y);
            add_br($sformatf("bgeu_%0d", p), ALU_BGEU, F3_BGEU, x, y);
        end
        add_row("load", ALU_NONE, {12'h004, 5'd1, 3'b010, 5'd6, 7'b0000011}, x, y);
        add_row("store", ALU_NONE, {7'd0, 5'd2, 5'd1, 3'b010, 5'd4, 7'b0100011}, x, y);
        add_row("csrrw", ALU_NONE, {12'h300, 5'd1, 3'b001, 5'd7, 7'b1110011}, x, y);
    endtask

    initial begin
        longint limit;
        wait (table_ready);
        limit = (rows.size() + 10) * 8 * 2;
        #(limit);
        $display("watchdog: run did not finish within %0d time units", limit);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        rst_n = 1'b0;
        req   = '0;
        void'($urandom(32'h3ebf_8d13));
        build_table();
        table_ready = 1'b1;
        req = rows[0]; // must be dropped while reset is held
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        req   = '0;
        for (int i = 0; i < rows.size(); i++) begin
            @(posedge clk);
            #1;
            req = rows[i];
            i_chk.push_expect(names[i], expect_wb(ops[i], rows[i]));
            if (gaps[i]) begin
                @(posedge clk);
                #1;
                req = '0; // bubble
            end
        end
        @(posedge clk);
        #1;
        req = '0;
        while (i_chk.pending() != 0) begin
            @(posedge clk);
        end
        repeat (3) @(posedge clk); // catch stray outputs
        i_chk.summarize();
        if (i_chk.error_count() == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
+incdir+src
src/ex_isa_pkg.sv
src/ex_pipe_pkg.sv
src/ex_decode.sv
src/ex_alu.sv
src/ex_mul.sv
src/ex_writeback.sv
src/ex_unit.sv
bench/ex_checker.sv
bench/tb_ex_unit.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_ex_unit
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
FILELIST  ?= project.f
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^PASS: all tests$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
